//--- hdl/csr_pkg.sv
package csr_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [11:0] csr_addr_t;

    typedef enum logic [2:0] {
        CSR_X     = 3'd0,
        CSR_W     = 3'd1,
        CSR_S     = 3'd2,
        CSR_C     = 3'd3,
        CSR_ECALL = 3'd4,
        CSR_MRET  = 3'd5
    } csr_cmd_t;

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_t;

    // User counters, read only
    localparam csr_addr_t ADDR_CYCLE    = 12'hc00;
    localparam csr_addr_t ADDR_TIME     = 12'hc01;
    localparam csr_addr_t ADDR_CYCLEH   = 12'hc80;
    localparam csr_addr_t ADDR_TIMEH    = 12'hc81;

    // Machine counters
    localparam csr_addr_t ADDR_MCYCLE   = 12'hb00;
    localparam csr_addr_t ADDR_MCYCLEH  = 12'hb80;

    // Machine information and trap setup
    localparam csr_addr_t ADDR_MHARTID  = 12'hf14;
    localparam csr_addr_t ADDR_MSTATUS  = 12'h300;
    localparam csr_addr_t ADDR_MISA     = 12'h301;
    localparam csr_addr_t ADDR_MIE      = 12'h304;
    localparam csr_addr_t ADDR_MTVEC    = 12'h305;

    // Machine trap handling
    localparam csr_addr_t ADDR_MSCRATCH = 12'h340;
    localparam csr_addr_t ADDR_MEPC     = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE   = 12'h342;
    localparam csr_addr_t ADDR_MIP      = 12'h344;

    // RV32 with A, I and M
    localparam xlen_t MISA_VALUE       = 32'h4000_1101;
    localparam xlen_t CAUSE_TIMER_INT  = 32'h8000_0007;
    // Plus the current mode, 8 for U and 11 for M
    localparam xlen_t CAUSE_ECALL_BASE = 32'd8;

    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_MPP_LO = 11;
    localparam int MSTATUS_MPP_HI = 12;
    localparam int MTIE_BIT       = 7;

endpackage

//--- hdl/csr_req_if.sv
interface csr_req_if
    import csr_pkg::*;
();

    csr_cmd_t  cmd;
    csr_addr_t addr;
    xlen_t     op1_data;
    priv_t     priv;

    modport ctrl (
        output cmd, addr, op1_data, priv
    );

    // Register file and write unit both sample the same request
    modport dp (
        input cmd, addr, op1_data, priv
    );

endinterface

//--- hdl/csr_trap_if.sv
interface csr_trap_if
    import csr_pkg::*;
();

    // Events from control, one cycle each
    logic  take_trap;
    xlen_t trap_cause;
    xlen_t trap_epc;
    logic  do_mret;

    // State back from the register file
    xlen_t mtvec;
    xlen_t mepc;
    priv_t mstatus_mpp;
    logic  mstatus_mie;
    logic  mie_mtie;

    modport ctrl (
        output take_trap, trap_cause, trap_epc, do_mret,
        input  mtvec, mepc, mstatus_mpp, mstatus_mie, mie_mtie
    );

    modport regs (
        input  take_trap, trap_cause, trap_epc, do_mret,
        output mtvec, mepc, mstatus_mpp, mstatus_mie, mie_mtie
    );

endinterface

//--- hdl/csr_control.sv
module csr_control
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        branch_hazard,
    input  csr_cmd_t    csr_cmd,
    input  xlen_t       op1_data,
    input  xlen_t       imm_i,
    input  logic [63:0] mtime,
    input  logic [63:0] mtimecmp,
    input  logic        interrupt_ready,
    input  xlen_t       fetch_pc,
    csr_req_if.ctrl     req,
    csr_trap_if.ctrl    trap,
    output csr_cmd_t    csr_cmd_out,
    output xlen_t       trap_vector,
    output logic        stall_may_interrupt
);

    priv_t mode;
    logic  timer_pending;
    logic  take_int;
    logic  ecall;

    assign timer_pending = mtime >= mtimecmp;

    // Pipeline must drain before the interrupt can be taken
    assign stall_may_interrupt = timer_pending && trap.mie_mtie &&
                                 (mode == PRIV_U || (mode == PRIV_M && trap.mstatus_mie));

    assign take_int = stall_may_interrupt && interrupt_ready;

    // Squashed request reads an unmapped address
    always_comb begin
        if (branch_hazard || take_int) begin
            req.cmd = CSR_X;
        end else begin
            req.cmd = csr_cmd;
        end
        req.addr     = branch_hazard ? '1 : imm_i[11:0];
        req.op1_data = op1_data;
        req.priv     = mode;
    end

    assign ecall = req.cmd == CSR_ECALL;

    assign trap.take_trap  = take_int || ecall;
    assign trap.do_mret    = req.cmd == CSR_MRET;
    assign trap.trap_cause = take_int ? CAUSE_TIMER_INT : CAUSE_ECALL_BASE + xlen_t'(mode);
    // ECALL leaves mepc to the handler
    assign trap.trap_epc   = take_int ? fetch_pc : trap.mepc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mode        <= PRIV_M;
            csr_cmd_out <= CSR_X;
            trap_vector <= '0;
        end else begin
            csr_cmd_out <= take_int ? CSR_ECALL : req.cmd;
            if (trap.take_trap) begin
                mode        <= PRIV_M;
                trap_vector <= trap.mtvec;
            end else if (trap.do_mret) begin
                mode        <= trap.mstatus_mpp;
                trap_vector <= trap.mepc;
            end
        end
    end

    // Return must never load a mode other than U or M
    assert property (@(posedge clk) disable iff (!rst_n)
        mode inside {PRIV_U, PRIV_M})
        else $error("mode left the U and M encodings");

endmodule

//--- hdl/csr_write_unit.sv
module csr_write_unit
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    csr_req_if.dp     req,
    input  xlen_t     rdata,
    output logic      wr_en,
    output csr_addr_t wr_addr,
    output xlen_t     wr_data
);

    csr_cmd_t  save_cmd;
    csr_addr_t save_addr;
    xlen_t     save_op1;
    priv_t     save_priv;
    logic      is_write;
    logic      writable;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            save_cmd <= CSR_X;
        end else begin
            save_cmd <= req.cmd;
        end
        save_addr <= req.addr;
        save_op1  <= req.op1_data;
        save_priv <= req.priv;
    end

    assign is_write = save_cmd inside {CSR_W, CSR_S, CSR_C};
    // Top two address bits set means a read-only CSR
    assign writable = (save_addr[9:8] <= save_priv) && (save_addr[11:10] != 2'b11);

    assign wr_en   = is_write && writable;
    assign wr_addr = save_addr;

    always_comb begin
        case (save_cmd)
            CSR_S:   wr_data = rdata | save_op1;
            CSR_C:   wr_data = rdata & ~save_op1;
            default: wr_data = save_op1;
        endcase
    end

    // Denied CSR must also have read as zero
    assert property (@(posedge clk) disable iff (!rst_n)
        is_write && (save_addr[9:8] > save_priv) |-> rdata == '0)
        else $error("denied CSR returned nonzero read data");

endmodule

//--- hdl/csr_machine_regs.sv
module csr_machine_regs
    import csr_pkg::*;
#(
    parameter xlen_t HART_ID = 32'd0
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [63:0] cycle,
    input  logic [63:0] mtime,
    input  logic [63:0] mtimecmp,
    csr_req_if.dp       req,
    csr_trap_if.regs    trap,
    input  logic        wr_en,
    input  csr_addr_t   wr_addr,
    input  xlen_t       wr_data,
    output xlen_t       rdata
);

    logic  mstatus_mie;
    logic  mstatus_mpie;
    priv_t mstatus_mpp;
    logic  mie_mtie;
    xlen_t mtvec;
    xlen_t mscratch;
    xlen_t mepc;
    xlen_t mcause;

    logic  mtip;
    logic  can_read;
    xlen_t mstatus_word;
    xlen_t mie_word;
    xlen_t mip_word;
    xlen_t rd_val;

    assign mtip = mtime >= mtimecmp;

    always_comb begin
        mstatus_word = '0;
        mstatus_word[MSTATUS_MIE]  = mstatus_mie;
        mstatus_word[MSTATUS_MPIE] = mstatus_mpie;
        mstatus_word[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = mstatus_mpp;
        mie_word = '0;
        mie_word[MTIE_BIT] = mie_mtie;
        mip_word = '0;
        mip_word[MTIE_BIT] = mtip;
    end

    assign can_read = req.addr[9:8] <= req.priv;

    always_comb begin
        case (req.addr)
            ADDR_CYCLE, ADDR_MCYCLE:   rd_val = cycle[31:0];
            ADDR_CYCLEH, ADDR_MCYCLEH: rd_val = cycle[63:32];
            ADDR_TIME:     rd_val = mtime[31:0];
            ADDR_TIMEH:    rd_val = mtime[63:32];
            ADDR_MHARTID:  rd_val = HART_ID;
            ADDR_MISA:     rd_val = MISA_VALUE;
            ADDR_MSTATUS:  rd_val = mstatus_word;
            ADDR_MIE:      rd_val = mie_word;
            ADDR_MTVEC:    rd_val = mtvec;
            ADDR_MSCRATCH: rd_val = mscratch;
            ADDR_MEPC:     rd_val = mepc;
            ADDR_MCAUSE:   rd_val = mcause;
            ADDR_MIP:      rd_val = mip_word;
            default:       rd_val = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata        <= '0;
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= PRIV_M;
            mie_mtie     <= 1'b0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
        end else begin
            rdata <= can_read ? rd_val : '0;
            if (trap.take_trap) begin
                mstatus_mpie <= mstatus_mie;
                mstatus_mie  <= 1'b0;
                mstatus_mpp  <= req.priv;
                mepc         <= {trap.trap_epc[31:1], 1'b0};
                mcause       <= trap.trap_cause;
            end else if (trap.do_mret) begin
                mstatus_mie <= mstatus_mpie;
                mstatus_mpp <= PRIV_U;
            end
            // Software write comes last so it overrides the trap update
            if (wr_en) begin
                case (wr_addr)
                    ADDR_MSTATUS: begin
                        mstatus_mie  <= wr_data[MSTATUS_MIE];
                        mstatus_mpie <= wr_data[MSTATUS_MPIE];
                        // Only U and M exist, anything else maps to U
                        mstatus_mpp  <= (wr_data[MSTATUS_MPP_HI:MSTATUS_MPP_LO] == PRIV_M) ?
                                        PRIV_M : PRIV_U;
                    end
                    ADDR_MIE:      mie_mtie <= wr_data[MTIE_BIT];
                    ADDR_MTVEC:    mtvec    <= wr_data;
                    ADDR_MSCRATCH: mscratch <= wr_data;
                    ADDR_MEPC:     mepc     <= {wr_data[31:1], 1'b0};
                    ADDR_MCAUSE:   mcause   <= wr_data;
                    default: ;
                endcase
            end
        end
    end

    assign trap.mtvec       = mtvec;
    assign trap.mepc        = mepc;
    assign trap.mstatus_mpp = mstatus_mpp;
    assign trap.mstatus_mie = mstatus_mie;
    assign trap.mie_mtie    = mie_mtie;

    // A return in the same cycle as a trap would be lost to the trap update
    assert property (@(posedge clk) disable iff (!rst_n)
        !(trap.take_trap && trap.do_mret))
        else $error("take_trap and do_mret both high");

endmodule

//--- hdl/csr_stage.sv
module csr_stage
    import csr_pkg::*;
#(
    parameter xlen_t HART_ID = 32'd0
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [63:0] cycle,
    input  logic [63:0] mtime,
    input  logic [63:0] mtimecmp,
    input  logic        branch_hazard,
    input  csr_cmd_t    csr_cmd,
    input  xlen_t       op1_data,
    input  xlen_t       imm_i,
    input  logic        interrupt_ready,
    input  xlen_t       fetch_pc,
    output csr_cmd_t    csr_cmd_out,
    output xlen_t       rdata,
    output xlen_t       trap_vector,
    output logic        stall_may_interrupt
);

    logic      wr_en;
    csr_addr_t wr_addr;
    xlen_t     wr_data;

    csr_req_if  req_if ();
    csr_trap_if trap_if ();

    csr_control control_i (
        .clk, .rst_n, .branch_hazard, .csr_cmd, .op1_data, .imm_i, .mtime, .mtimecmp,
        .interrupt_ready, .fetch_pc, .req(req_if.ctrl), .trap(trap_if.ctrl),
        .csr_cmd_out, .trap_vector, .stall_may_interrupt
    );

    csr_write_unit write_unit_i (
        .clk, .rst_n, .req(req_if.dp), .rdata, .wr_en, .wr_addr, .wr_data
    );

    csr_machine_regs #(.HART_ID(HART_ID)) machine_regs_i (
        .clk, .rst_n, .cycle, .mtime, .mtimecmp, .req(req_if.dp), .trap(trap_if.regs),
        .wr_en, .wr_addr, .wr_data, .rdata
    );

endmodule

//--- bench/csr_stage_tb.sv
module csr_stage_tb
    import csr_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam xlen_t HART_ID = 32'h0000_0003;
    // Directed sequence is about 90 cycles long
    localparam int TIMEOUT_CYCLES = 400;

    logic        clk;
    logic        rst_n;
    logic [63:0] cycle = 64'h1234_5678_0000_0100;
    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic        branch_hazard;
    csr_cmd_t    csr_cmd;
    xlen_t       op1_data;
    xlen_t       imm_i;
    logic        interrupt_ready;
    xlen_t       fetch_pc;
    csr_cmd_t    csr_cmd_out;
    xlen_t       rdata;
    xlen_t       trap_vector;
    logic        stall_may_interrupt;

    int checks = 0;
    int errors = 0;
    int cycles = 0;

    // Reference model state
    priv_t model_mode;
    xlen_t model_mscratch;
    xlen_t model_mtvec;
    xlen_t model_mepc;
    xlen_t model_mcause;

    csr_stage #(.HART_ID(HART_ID)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Free-running counter input and run limit
    always @(posedge clk) begin
        cycle  <= cycle + 64'd1;
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: sequence did not finish in %0d cycles, %0d errors", cycles, errors);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic check(input string name, input xlen_t expected, input xlen_t actual);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("Error in %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // One request then one idle cycle, returns when rdata and csr_cmd_out hold the result
    task automatic send(input csr_cmd_t cmd, input csr_addr_t addr, input xlen_t data,
                        input logic hazard);
        @(posedge clk);
        csr_cmd       <= cmd;
        imm_i         <= {20'd0, addr};
        op1_data      <= data;
        branch_hazard <= hazard;
        @(posedge clk);
        csr_cmd       <= CSR_X;
        imm_i         <= '0;
        op1_data      <= '0;
        branch_hazard <= 1'b0;
        @(negedge clk);
    endtask

    // Plain read, set with zero data
    task automatic read_check(input string name, input csr_addr_t addr, input xlen_t expected);
        send(CSR_S, addr, '0, 1'b0);
        check(name, expected, rdata);
    endtask

    task automatic rmw_test(input string name, input csr_addr_t addr, output xlen_t final_val);
        xlen_t expected;
        xlen_t data;
        data = $urandom;
        send(CSR_W, addr, data, 1'b0);
        expected = data;
        read_check({name, " W"}, addr, expected);
        data = $urandom;
        send(CSR_S, addr, data, 1'b0);
        check({name, " S old value"}, expected, rdata);
        expected = expected | data;
        read_check({name, " S"}, addr, expected);
        data = $urandom;
        send(CSR_C, addr, data, 1'b0);
        check({name, " C old value"}, expected, rdata);
        expected = expected & ~data;
        read_check({name, " C"}, addr, expected);
        final_val = expected;
    endtask

    task automatic ecall_check(input string name);
        xlen_t cause;
        // Code 8 from U, 11 from M
        cause = (model_mode == PRIV_M) ? 32'd11 : 32'd8;
        send(CSR_ECALL, '0, '0, 1'b0);
        check({name, " cmd"}, xlen_t'(CSR_ECALL), xlen_t'(csr_cmd_out));
        check({name, " vector"}, model_mtvec, trap_vector);
        model_mode   = PRIV_M;
        model_mcause = cause;
        read_check({name, " mcause"}, ADDR_MCAUSE, model_mcause);
    endtask

    initial begin
        xlen_t data;
        void'($urandom(32'h4ef1));
        rst_n           = 1'b0;
        mtime           = '0;
        mtimecmp        = '1;
        branch_hazard   = 1'b0;
        csr_cmd         = CSR_X;
        op1_data        = '0;
        imm_i           = '0;
        interrupt_ready = 1'b0;
        fetch_pc        = '0;
        model_mode      = PRIV_M;
        model_mscratch  = '0;
        model_mtvec     = '0;
        model_mepc      = '0;
        model_mcause    = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        rmw_test("mscratch", ADDR_MSCRATCH, model_mscratch);
        rmw_test("mtvec", ADDR_MTVEC, model_mtvec);

        // Constants, unmapped space and counters
        read_check("misa", ADDR_MISA, MISA_VALUE);
        send(CSR_W, ADDR_MISA, $urandom, 1'b0);
        read_check("misa after W", ADDR_MISA, MISA_VALUE);
        read_check("mhartid", ADDR_MHARTID, HART_ID);
        read_check("unmapped", 12'h7c0, '0);
        send(CSR_S, ADDR_CYCLE, '0, 1'b0);
        checks++;
        assert (cycle[31:0] - rdata <= 32'd1) else begin
            errors++;
            $display("Error in cycle: expected %h or one less, actual %h", cycle[31:0], rdata);
        end
        read_check("cycleh", ADDR_CYCLEH, cycle[63:32]);

        ecall_check("ecall M");

        // MPP = U, then return to a random mepc
        send(CSR_W, ADDR_MSTATUS, '0, 1'b0);
        data = $urandom;
        send(CSR_W, ADDR_MEPC, data, 1'b0);
        model_mepc = {data[31:1], 1'b0};
        read_check("mepc", ADDR_MEPC, model_mepc);
        send(CSR_MRET, '0, '0, 1'b0);
        check("mret cmd", xlen_t'(CSR_MRET), xlen_t'(csr_cmd_out));
        check("mret vector", model_mepc, trap_vector);
        model_mode = PRIV_U;
        read_check("mscratch in U", ADDR_MSCRATCH, '0);
        send(CSR_W, ADDR_MSCRATCH, $urandom, 1'b0);
        ecall_check("ecall U");
        read_check("mscratch kept", ADDR_MSCRATCH, model_mscratch);

        // Timer interrupt with MTIE and MIE set
        send(CSR_W, ADDR_MIE, 32'h80, 1'b0);
        send(CSR_W, ADDR_MSTATUS, 32'h8, 1'b0);
        data = $urandom;
        @(posedge clk);
        mtime    <= 64'd200;
        mtimecmp <= 64'd100;
        fetch_pc <= data;
        @(negedge clk);
        check("stall raised", 32'd1, {31'd0, stall_may_interrupt});
        @(posedge clk);
        interrupt_ready <= 1'b1;
        @(posedge clk);
        interrupt_ready <= 1'b0;
        @(negedge clk);
        check("timer cmd", xlen_t'(CSR_ECALL), xlen_t'(csr_cmd_out));
        check("timer vector", model_mtvec, trap_vector);
        check("stall released", 32'd0, {31'd0, stall_may_interrupt});
        model_mepc   = {data[31:1], 1'b0};
        model_mcause = CAUSE_TIMER_INT;
        read_check("timer mepc", ADDR_MEPC, model_mepc);
        read_check("timer mcause", ADDR_MCAUSE, model_mcause);
        @(posedge clk);
        mtimecmp <= '1;

        // Squashed write
        send(CSR_W, ADDR_MSCRATCH, $urandom, 1'b1);
        check("hazard cmd", xlen_t'(CSR_X), xlen_t'(csr_cmd_out));
        check("hazard read", '0, rdata);
        read_check("hazard mscratch", ADDR_MSCRATCH, model_mscratch);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
hdl/csr_pkg.sv
hdl/csr_req_if.sv
hdl/csr_trap_if.sv
hdl/csr_control.sv
hdl/csr_write_unit.sv
hdl/csr_machine_regs.sv
hdl/csr_stage.sv
bench/csr_stage_tb.sv

//--- Makefile
TOP := csr_stage_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f tb.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '^Test OK$$' sim.log

clean:
	rm -rf obj_dir sim.log
